// File: build.f
hdl/mc_regs_pkg.sv
hdl/mc_line_pkg.sv
hdl/mc_clock_gen.sv
hdl/mc_shifter.sv
hdl/mc_channel_fsm.sv
hdl/mc_csr_regs.sv
hdl/memcard.sv
tb/tb_clock.sv
tb/memcard_tb.sv

// File: Makefile
# Verilator build and run for the memory card controller testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = memcard_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the log holds the pass message
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/memcard_tb.sv
// ----------------------------------------------------------
// memory card controller testbench
// card model on the command and data lines, register bus
// stimulus, reference values and per test reporting
// ----------------------------------------------------------
`timescale 1ns/1ps

module memcard_tb;
	import mc_regs_pkg::*;
	import mc_line_pkg::*;

	localparam int clk_period_ns = 40;
	localparam int max_cycles = 60000;
	localparam int n_bytes = 8;
	localparam int n_words = 8;
	localparam int n_rx = 3;

	logic        sys_clk;
	logic        sys_rst;
	logic [13:0] csr_a;
	logic        csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic [0:0]  mc_cmd_i;
	logic [0:0]  mc_cmd_o;
	logic [0:0]  mc_cmd_oe;
	logic [3:0]  mc_d_i;
	logic [3:0]  mc_d_o;
	logic [3:0]  mc_d_oe;
	logic        mc_clk;

	integer  seed = 32'hcf434bf6;
	int      checks;
	int      errors;
	int      test_errors;
	int      cycle_cnt;
	// groups seen by the card on each rising mc_clk
	logic [3:0] cmd_got [$];
	logic [3:0] dat_got [$];
	realtime    cmd_rise [$];
	// groups the card sends, one per falling mc_clk
	logic [3:0] cmd_pat [16];
	logic [3:0] dat_pat [16];
	int         cmd_pat_len;
	int         dat_pat_len;
	int         cmd_pat_gen;
	int         dat_pat_gen;

	tb_clock #(
		.period_ns(clk_period_ns),
		.reset_cycles(4)
	) u_clock (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst)
	);

	memcard #(
		.csr_base(4'h0)
	) uut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.mc_cmd_i(mc_cmd_i),
		.mc_cmd_o(mc_cmd_o),
		.mc_cmd_oe(mc_cmd_oe),
		.mc_d_i(mc_d_i),
		.mc_d_o(mc_d_o),
		.mc_d_oe(mc_d_oe),
		.mc_clk(mc_clk)
	);

	// card side sampling, taken half a cycle after the rising edge
	always @(posedge mc_clk) begin : line_capture
		realtime t;
		t = $realtime;
		@(negedge sys_clk);
		if (mc_cmd_oe[0]) begin
			cmd_got.push_back({3'b000, mc_cmd_o});
			cmd_rise.push_back(t);
		end
		if (mc_d_oe == 4'hf)
			dat_got.push_back(mc_d_o);
	end

	// card side driving, lines idle high once a pattern runs out
	initial begin : line_drive
		int cmd_idx;
		int dat_idx;
		int cmd_seen;
		int dat_seen;
		cmd_idx = 0;
		dat_idx = 0;
		cmd_seen = 0;
		dat_seen = 0;
		mc_cmd_i = 1'b1;
		mc_d_i = 4'hf;
		forever begin
			@(negedge mc_clk);
			@(negedge sys_clk);
			if (cmd_pat_gen != cmd_seen) begin
				cmd_seen = cmd_pat_gen;
				cmd_idx = 0;
			end
			if (dat_pat_gen != dat_seen) begin
				dat_seen = dat_pat_gen;
				dat_idx = 0;
			end
			if (cmd_idx < cmd_pat_len) begin
				mc_cmd_i = cmd_pat[cmd_idx][0];
				cmd_idx++;
			end else begin
				mc_cmd_i = 1'b1;
			end
			if (dat_idx < dat_pat_len) begin
				mc_d_i = dat_pat[dat_idx];
				dat_idx++;
			end else begin
				mc_d_i = 4'hf;
			end
		end
	end

	// group idx of a transmitted value, most significant group first
	function automatic logic [3:0] group_at(input logic [31:0] value, input int lanes,
		input int bits, input int idx);
		logic [31:0] shifted;
		shifted = value >> (bits - lanes * (idx + 1));
		return 4'(shifted & ((32'd1 << lanes) - 32'd1));
	endfunction

	// value built from the first all-zero group onwards
	function automatic logic [31:0] expected_rx(input logic [3:0] pat [16], input int len,
		input int lanes, input int bits);
		logic [31:0] acc;
		logic [3:0]  mask;
		logic [3:0]  grp;
		int          first;
		mask = 4'((32'd1 << lanes) - 32'd1);
		first = -1;
		acc = '0;
		for (int i = 0; i < len; i++)
			if (first < 0 && (pat[i] & mask) == 4'h0)
				first = i;
		if (first >= 0) begin
			for (int k = 0; k < bits / lanes; k++) begin
				grp = mask;
				if (first + k < len)
					grp = pat[first + k];
				acc = (acc << lanes) | 32'(grp & mask);
			end
		end
		return acc;
	endfunction

	task automatic write_reg(input mc_reg_t idx, input logic [31:0] data);
		@(negedge sys_clk);
		csr_a = {11'd0, idx};
		csr_we = 1'b1;
		csr_di = data;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic read_reg(input mc_reg_t idx, output logic [31:0] data);
		@(negedge sys_clk);
		csr_a = {11'd0, idx};
		csr_we = 1'b0;
		@(negedge sys_clk);
		data = csr_do;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic count_toggles(input int cycles, output int toggles);
		logic last;
		toggles = 0;
		last = mc_clk;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (mc_clk !== last)
				toggles++;
			last = mc_clk;
		end
	endtask

	// reads reg_pending until one bit reaches the wanted level
	task automatic poll_status(input int bit_pos, input logic level, input string what);
		logic [31:0] data;
		int          tries;
		tries = 0;
		checks++;
		read_reg(reg_pending, data);
		while (data[bit_pos] !== level && tries < 200) begin
			read_reg(reg_pending, data);
			tries++;
		end
		if (data[bit_pos] !== level) begin
			$display("%s bit never reached %0d at %0t ns", what, level, $time);
			errors++;
			test_errors++;
		end
	endtask

	task automatic send_value(input bit dat, input logic [31:0] value, output int base);
		mc_reg_t     r;
		string       name;
		int          lanes;
		int          bits;
		int          toggles;
		logic [31:0] got;
		lanes = dat ? dat_lanes : cmd_lanes;
		bits = dat ? dat_bits : cmd_bits;
		r = dat ? reg_dat : reg_cmd;
		name = dat ? "mc_d_o" : "mc_cmd_o";
		base = dat ? dat_got.size() : cmd_got.size();
		write_reg(r, value);
		while ((dat ? dat_got.size() : cmd_got.size()) < base + bits / lanes)
			@(posedge sys_clk);
		for (int i = 0; i < bits / lanes; i++) begin
			got = dat ? 32'(dat_got[base + i]) : 32'(cmd_got[base + i]);
			check_value(name, got, 32'(group_at(value, lanes, bits, i)));
		end
		poll_status(dat ? en_dat_tx : en_cmd_tx, 1'b0, "transmit pending");
		// nothing left to send, so the card clock must hold
		count_toggles(24, toggles);
		check_value("mc_clk toggles after transmit", 32'(toggles), 32'd0);
	endtask

	task automatic receive_value(input bit dat);
		logic [3:0]  pat [16];
		logic [3:0]  mask;
		logic [31:0] exp;
		logic [31:0] data;
		int          lanes;
		int          bits;
		int          toggles;
		lanes = dat ? dat_lanes : cmd_lanes;
		bits = dat ? dat_bits : cmd_bits;
		mask = 4'((32'd1 << lanes) - 32'd1);
		for (int i = 0; i < 16; i++)
			pat[i] = mask;
		pat[2] = 4'h0;
		for (int i = 3; i < 10; i++)
			pat[i] = 4'($random(seed)) & mask;
		exp = expected_rx(pat, 10, lanes, bits);
		if (dat) begin
			dat_pat = pat;
			dat_pat_len = 10;
			dat_pat_gen++;
		end else begin
			cmd_pat = pat;
			cmd_pat_len = 10;
			cmd_pat_gen++;
		end
		poll_status(dat ? en_dat_rx : en_cmd_rx, 1'b1, "receive pending");
		read_reg(dat ? reg_dat : reg_cmd, data);
		check_value(dat ? "reg_dat" : "reg_cmd", data, exp);
		read_reg(reg_started, data);
		check_value("reg_started", data, dat ? 32'd2 : 32'd1);
		// unread value holds the card clock
		count_toggles(24, toggles);
		check_value("mc_clk toggles while full", 32'(toggles), 32'd0);
		write_reg(reg_pending, 32'd1 << (dat ? en_dat_rx : en_cmd_rx));
		read_reg(reg_pending, data);
		check_value("reg_pending after ack", data, 32'd0);
		read_reg(reg_started, data);
		check_value("reg_started after ack", data, 32'd0);
		count_toggles(16, toggles);
		check_value("mc_clk running after ack", 32'(toggles != 0), 32'd1);
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// run limit, far above the length of all tests at divider 3
	initial begin : run_limit
		cycle_cnt = 0;
		while (cycle_cnt < max_cycles) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles without reaching the end", max_cycles);
		$display("test failed");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] data;
		logic [31:0] value;
		int          toggles;
		int          base;
		int          span;
		// start outside the register window, where csr_do reads zero
		csr_a = 14'h3c00;
		csr_we = 1'b0;
		csr_di = '0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		cmd_pat_len = 0;
		dat_pat_len = 0;
		cmd_pat_gen = 0;
		dat_pat_gen = 0;
		@(posedge sys_clk);
		while (sys_rst !== 1'b0)
			@(posedge sys_clk);
		@(negedge sys_clk);

		check_value("csr_do", csr_do, 32'd0);
		check_value("mc_cmd_oe", 32'(mc_cmd_oe), 32'd0);
		check_value("mc_d_oe", 32'(mc_d_oe), 32'd0);
		read_reg(reg_divider, data);
		check_value("reg_divider", data, 32'd1023);
		read_reg(reg_enable, data);
		check_value("reg_enable", data, 32'd0);
		read_reg(reg_pending, data);
		check_value("reg_pending", data, 32'd0);
		read_reg(reg_started, data);
		check_value("reg_started", data, 32'd0);
		report_test("test 1 reset values");

		write_reg(reg_enable, 32'd1 << en_cmd_tx);
		write_reg(reg_divider, 32'd3);
		count_toggles(40, toggles);
		check_value("mc_clk toggles before load", 32'(toggles), 32'd0);
		value = 32'($random(seed)) & 32'hff;
		send_value(1'b0, value, base);
		// 2 x (3 + 1) sys_clk cycles between rising edges
		for (int i = 1; i < cmd_bits; i++) begin
			span = int'((cmd_rise[base + i] - cmd_rise[base + i - 1]) / clk_period_ns);
			check_value("mc_clk period", 32'(span), 32'd8);
		end
		report_test("test 2 clock hold and period");

		repeat (n_bytes) begin
			value = 32'($random(seed)) & 32'hff;
			send_value(1'b0, value, base);
		end
		report_test("test 3 command transmit");

		write_reg(reg_enable, 32'd1 << en_dat_tx);
		repeat (n_words) begin
			value = 32'($random(seed));
			send_value(1'b1, value, base);
		end
		report_test("test 4 data transmit");

		write_reg(reg_enable, 32'd1 << en_cmd_rx);
		repeat (n_rx)
			receive_value(1'b0);
		report_test("test 5 command receive");

		write_reg(reg_enable, 32'd1 << en_dat_rx);
		repeat (n_rx)
			receive_value(1'b1);
		report_test("test 6 data receive");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
// ----------------------------------------------------------
// testbench clock and reset
// free running sys_clk and a synchronous reset that is
// released on a falling edge after a fixed number of cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns = 40,
	parameter int reset_cycles = 4
) (
	output logic sys_clk,
	output logic sys_rst
);

	initial begin
		sys_clk = 1'b0;
		forever #(period_ns / 2) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst = 1'b1;
		repeat (reset_cycles) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
	end

endmodule

// File: hdl/memcard.sv
// ----------------------------------------------------------
// memory card line controller, top level
// register block, card clock generator and one command and
// one data channel, each line as separate in, out and enable
// ----------------------------------------------------------
`timescale 1ns/1ps

module memcard #(
	parameter logic [3:0] csr_base = 4'h0
) (
	input  logic                                sys_clk,
	input  logic                                sys_rst,
	input  logic [mc_regs_pkg::csr_addr_w-1:0]  csr_a,
	input  logic                                csr_we,
	input  logic [mc_regs_pkg::csr_data_w-1:0]  csr_di,
	output logic [mc_regs_pkg::csr_data_w-1:0]  csr_do,
	input  logic [mc_line_pkg::cmd_lanes-1:0]   mc_cmd_i,
	output logic [mc_line_pkg::cmd_lanes-1:0]   mc_cmd_o,
	output logic [mc_line_pkg::cmd_lanes-1:0]   mc_cmd_oe,
	input  logic [mc_line_pkg::dat_lanes-1:0]   mc_d_i,
	output logic [mc_line_pkg::dat_lanes-1:0]   mc_d_o,
	output logic [mc_line_pkg::dat_lanes-1:0]   mc_d_oe,
	output logic                                mc_clk
);
	import mc_regs_pkg::*;
	import mc_line_pkg::*;

	logic [div_w-1:0]    div_factor;
	logic                shift_stb;
	logic                cmd_tx_en;
	logic                cmd_rx_en;
	logic                cmd_tx_load;
	logic                cmd_rx_ack;
	logic [cmd_bits-1:0] cmd_load_value;
	logic [cmd_bits-1:0] cmd_value;
	logic                cmd_tx_pending;
	logic                cmd_rx_pending;
	logic                cmd_rx_started;
	logic                cmd_hold;
	logic                cmd_shift_en;
	logic                cmd_clear_count;
	logic                cmd_start_seen;
	logic                cmd_last_bit;
	logic                dat_tx_en;
	logic                dat_rx_en;
	logic                dat_tx_load;
	logic                dat_rx_ack;
	logic [dat_bits-1:0] dat_load_value;
	logic [dat_bits-1:0] dat_value;
	logic                dat_tx_pending;
	logic                dat_rx_pending;
	logic                dat_rx_started;
	logic                dat_hold;
	logic                dat_shift_en;
	logic                dat_clear_count;
	logic                dat_start_seen;
	logic                dat_last_bit;

	mc_csr_regs #(
		.csr_base(csr_base)
	) u_regs (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.div_factor(div_factor),
		.cmd_tx_en(cmd_tx_en),
		.cmd_rx_en(cmd_rx_en),
		.dat_tx_en(dat_tx_en),
		.dat_rx_en(dat_rx_en),
		.cmd_tx_load(cmd_tx_load),
		.dat_tx_load(dat_tx_load),
		.cmd_rx_ack(cmd_rx_ack),
		.dat_rx_ack(dat_rx_ack),
		.cmd_load_value(cmd_load_value),
		.dat_load_value(dat_load_value),
		.cmd_tx_pending(cmd_tx_pending),
		.cmd_rx_pending(cmd_rx_pending),
		.cmd_rx_started(cmd_rx_started),
		.dat_tx_pending(dat_tx_pending),
		.dat_rx_pending(dat_rx_pending),
		.dat_rx_started(dat_rx_started),
		.cmd_value(cmd_value),
		.dat_value(dat_value)
	);

	mc_clock_gen u_clock (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.div_factor(div_factor),
		.cmd_hold(cmd_hold),
		.dat_hold(dat_hold),
		.mc_clk(mc_clk),
		.shift_stb(shift_stb)
	);

	// command channel
	mc_channel_fsm u_cmd_fsm (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tx_en(cmd_tx_en),
		.rx_en(cmd_rx_en),
		.tx_load(cmd_tx_load),
		.rx_ack(cmd_rx_ack),
		.shift_stb(shift_stb),
		.start_seen(cmd_start_seen),
		.last_bit(cmd_last_bit),
		.shift_en(cmd_shift_en),
		.clear_count(cmd_clear_count),
		.tx_pending(cmd_tx_pending),
		.rx_pending(cmd_rx_pending),
		.rx_started(cmd_rx_started),
		.clk_hold(cmd_hold)
	);

	mc_shifter #(
		.lanes(cmd_lanes),
		.bits(cmd_bits)
	) u_cmd_shift (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.line_in(mc_cmd_i),
		.line_out(mc_cmd_o),
		.line_oe(mc_cmd_oe),
		.drive(cmd_tx_en),
		.load(cmd_tx_load),
		.load_value(cmd_load_value),
		.shift_en(cmd_shift_en),
		.clear_count(cmd_clear_count),
		.shift_stb(shift_stb),
		.value(cmd_value),
		.start_seen(cmd_start_seen),
		.last_bit(cmd_last_bit)
	);

	// data channel
	mc_channel_fsm u_dat_fsm (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tx_en(dat_tx_en),
		.rx_en(dat_rx_en),
		.tx_load(dat_tx_load),
		.rx_ack(dat_rx_ack),
		.shift_stb(shift_stb),
		.start_seen(dat_start_seen),
		.last_bit(dat_last_bit),
		.shift_en(dat_shift_en),
		.clear_count(dat_clear_count),
		.tx_pending(dat_tx_pending),
		.rx_pending(dat_rx_pending),
		.rx_started(dat_rx_started),
		.clk_hold(dat_hold)
	);

	mc_shifter #(
		.lanes(dat_lanes),
		.bits(dat_bits)
	) u_dat_shift (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.line_in(mc_d_i),
		.line_out(mc_d_o),
		.line_oe(mc_d_oe),
		.drive(dat_tx_en),
		.load(dat_tx_load),
		.load_value(dat_load_value),
		.shift_en(dat_shift_en),
		.clear_count(dat_clear_count),
		.shift_stb(shift_stb),
		.value(dat_value),
		.start_seen(dat_start_seen),
		.last_bit(dat_last_bit)
	);

endmodule

// File: hdl/mc_csr_regs.sv
// ----------------------------------------------------------
// memory card register block
// decodes the register window, keeps divider and enables,
// issues load and acknowledge pulses, registers the read data
// ----------------------------------------------------------
`timescale 1ns/1ps

module mc_csr_regs #(
	parameter logic [3:0] csr_base = 4'h0
) (
	input  logic                               sys_clk,
	input  logic                               sys_rst,
	input  logic [mc_regs_pkg::csr_addr_w-1:0] csr_a,
	input  logic                               csr_we,
	input  logic [mc_regs_pkg::csr_data_w-1:0] csr_di,
	output logic [mc_regs_pkg::csr_data_w-1:0] csr_do,
	output logic [mc_regs_pkg::div_w-1:0]      div_factor,
	output logic                               cmd_tx_en,
	output logic                               cmd_rx_en,
	output logic                               dat_tx_en,
	output logic                               dat_rx_en,
	output logic                               cmd_tx_load,
	output logic                               dat_tx_load,
	output logic                               cmd_rx_ack,
	output logic                               dat_rx_ack,
	output logic [mc_line_pkg::cmd_bits-1:0]   cmd_load_value,
	output logic [mc_line_pkg::dat_bits-1:0]   dat_load_value,
	input  logic                               cmd_tx_pending,
	input  logic                               cmd_rx_pending,
	input  logic                               cmd_rx_started,
	input  logic                               dat_tx_pending,
	input  logic                               dat_rx_pending,
	input  logic                               dat_rx_started,
	input  logic [mc_line_pkg::cmd_bits-1:0]   cmd_value,
	input  logic [mc_line_pkg::dat_bits-1:0]   dat_value
);
	import mc_regs_pkg::*;
	import mc_line_pkg::*;

	logic                  sel;
	logic                  wr;
	mc_reg_t               reg_idx;
	logic [csr_data_w-1:0] enable_word;
	logic [csr_data_w-1:0] pending_word;
	logic [csr_data_w-1:0] started_word;

	assign sel = (csr_a[csr_addr_w-1 -: 4] == csr_base);
	assign wr = sel && csr_we;
	assign reg_idx = mc_reg_t'(csr_a[2:0]);

	// control registers and one-cycle pulses
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_factor <= div_reset;
			cmd_tx_en <= 1'b0;
			cmd_rx_en <= 1'b0;
			dat_tx_en <= 1'b0;
			dat_rx_en <= 1'b0;
			cmd_tx_load <= 1'b0;
			dat_tx_load <= 1'b0;
			cmd_rx_ack <= 1'b0;
			dat_rx_ack <= 1'b0;
		end else begin
			cmd_tx_load <= 1'b0;
			dat_tx_load <= 1'b0;
			cmd_rx_ack <= 1'b0;
			dat_rx_ack <= 1'b0;
			if (wr) begin
				case (reg_idx)
					reg_divider: div_factor <= csr_di[div_w-1:0];
					reg_enable: begin
						cmd_tx_en <= csr_di[en_cmd_tx];
						cmd_rx_en <= csr_di[en_cmd_rx];
						dat_tx_en <= csr_di[en_dat_tx];
						dat_rx_en <= csr_di[en_dat_rx];
					end
					// receive bits acknowledge, transmit bits are ignored
					reg_pending: begin
						cmd_rx_ack <= csr_di[en_cmd_rx];
						dat_rx_ack <= csr_di[en_dat_rx];
					end
					reg_cmd: cmd_tx_load <= 1'b1;
					reg_dat: dat_tx_load <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// transmit values, captured together with the load pulse
	always_ff @(posedge sys_clk) begin
		if (wr && reg_idx == reg_cmd)
			cmd_load_value <= csr_di[cmd_bits-1:0];
		if (wr && reg_idx == reg_dat)
			dat_load_value <= csr_di[dat_bits-1:0];
	end

	always_comb begin
		enable_word = '0;
		enable_word[en_cmd_tx] = cmd_tx_en;
		enable_word[en_cmd_rx] = cmd_rx_en;
		enable_word[en_dat_tx] = dat_tx_en;
		enable_word[en_dat_rx] = dat_rx_en;
		pending_word = '0;
		pending_word[en_cmd_tx] = cmd_tx_pending;
		pending_word[en_cmd_rx] = cmd_rx_pending;
		pending_word[en_dat_tx] = dat_tx_pending;
		pending_word[en_dat_rx] = dat_rx_pending;
		// started has one bit per channel, command first
		started_word = '0;
		started_word[0] = cmd_rx_started;
		started_word[1] = dat_rx_started;
	end

	// registered read, zero outside the window
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (sel) begin
				case (reg_idx)
					reg_divider: csr_do <= csr_data_w'(div_factor);
					reg_enable:  csr_do <= enable_word;
					reg_pending: csr_do <= pending_word;
					reg_started: csr_do <= started_word;
					reg_cmd:     csr_do <= csr_data_w'(cmd_value);
					reg_dat:     csr_do <= csr_data_w'(dat_value);
					default:     csr_do <= '0;
				endcase
			end
		end
	end

endmodule

// File: hdl/mc_channel_fsm.sv
// ----------------------------------------------------------
// memory card channel controller
// sequences transmit and receive for one line group, reports
// pending and started status and holds the card clock
// ----------------------------------------------------------
`timescale 1ns/1ps

module mc_channel_fsm (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic tx_en,
	input  logic rx_en,
	input  logic tx_load,
	input  logic rx_ack,
	input  logic shift_stb,
	input  logic start_seen,
	input  logic last_bit,
	output logic shift_en,
	output logic clear_count,
	output logic tx_pending,
	output logic rx_pending,
	output logic rx_started,
	output logic clk_hold
);
	import mc_line_pkg::*;

	mc_chan_state_t state;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ch_idle;
		end else if (tx_load) begin
			// transmit wins over any receive in progress
			state <= ch_tx;
		end else begin
			case (state)
				ch_idle: begin
					if (rx_en)
						state <= ch_rx_hunt;
				end
				ch_tx: begin
					if (shift_stb && last_bit)
						state <= ch_idle;
				end
				ch_rx_hunt: begin
					if (!rx_en)
						state <= ch_idle;
					else if (shift_stb && start_seen)
						state <= ch_rx_shift;
				end
				ch_rx_shift: begin
					if (!rx_en)
						state <= ch_idle;
					else if (shift_stb && last_bit)
						state <= ch_rx_full;
				end
				ch_rx_full: begin
					if (!rx_en)
						state <= ch_idle;
					else if (rx_ack)
						state <= ch_rx_hunt;
				end
				default: state <= ch_idle;
			endcase
		end
	end

	// the start group itself is shifted in while hunting
	assign shift_en = (state == ch_tx) || (state == ch_rx_shift)
		|| (state == ch_rx_hunt && start_seen);

	// counter restarts on a new value, on acknowledge and whenever idle
	assign clear_count = tx_load || rx_ack || (state == ch_idle);

	assign tx_pending = (state == ch_tx);
	assign rx_pending = (state == ch_rx_full);
	assign rx_started = (state == ch_rx_shift) || (state == ch_rx_full);

	// stop the card clock with nothing to send or an unread value
	assign clk_hold = (tx_en && state != ch_tx) || (state == ch_rx_full);

	// a held channel gets no shift strobe once the strobe delay has drained
	a_no_stb_while_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		clk_hold && $past(clk_hold) && $past(clk_hold, 2) |-> !shift_stb);

endmodule

// File: hdl/mc_shifter.sv
// ----------------------------------------------------------
// memory card line shifter
// synchronizes the incoming lanes, shifts groups in and out
// most significant first and counts the groups of one value
// ----------------------------------------------------------
`timescale 1ns/1ps

module mc_shifter #(
	parameter int lanes = mc_line_pkg::cmd_lanes,
	parameter int bits = mc_line_pkg::cmd_bits
) (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic [lanes-1:0] line_in,
	output logic [lanes-1:0] line_out,
	output logic [lanes-1:0] line_oe,
	input  logic             drive,
	input  logic             load,
	input  logic [bits-1:0]  load_value,
	input  logic             shift_en,
	input  logic             clear_count,
	input  logic             shift_stb,
	output logic [bits-1:0]  value,
	output logic             start_seen,
	output logic             last_bit
);
	import mc_line_pkg::*;

	localparam int groups = bits / lanes;
	localparam int cnt_w = (groups > 1) ? $clog2(groups) : 1;

	logic [lanes-1:0] sync_q [sync_depth];
	logic [lanes-1:0] line_sync;
	logic [bits-1:0]  sreg;
	logic [cnt_w-1:0] group_cnt;

	// input synchronizer chain
	always_ff @(posedge sys_clk) begin
		sync_q[0] <= line_in;
		for (int i = 1; i < sync_depth; i++)
			sync_q[i] <= sync_q[i-1];
	end

	assign line_sync = sync_q[sync_depth-1];

	// a start group is all lanes low
	assign start_seen = (line_sync == '0);

	// shift register, new groups enter at the bottom
	always_ff @(posedge sys_clk) begin
		if (load)
			sreg <= load_value;
		else if (shift_stb && shift_en)
			sreg <= {sreg[bits-lanes-1:0], line_sync};
	end

	// group counter, wraps after one full value
	always_ff @(posedge sys_clk) begin
		if (sys_rst || clear_count) begin
			group_cnt <= '0;
		end else if (shift_stb && shift_en) begin
			if (last_bit)
				group_cnt <= '0;
			else
				group_cnt <= group_cnt + 1'b1;
		end
	end

	assign last_bit = (group_cnt == cnt_w'(groups - 1));

	// top group goes out on the lines
	assign line_out = sreg[bits-1 -: lanes];
	assign line_oe = {lanes{drive}};
	assign value = sreg;

endmodule

// File: hdl/mc_clock_gen.sv
// ----------------------------------------------------------
// memory card clock generator
// divides sys_clk down to the card clock and places the
// internal shift strobe two cycles after each rising edge
// ----------------------------------------------------------
`timescale 1ns/1ps

module mc_clock_gen (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic [mc_regs_pkg::div_w-1:0] div_factor,
	input  logic                         cmd_hold,
	input  logic                         dat_hold,
	output logic                         mc_clk,
	output logic                         shift_stb
);
	import mc_regs_pkg::*;

	logic [div_w-1:0] div_cnt;
	logic             tick;
	logic             clk_q;
	logic             stb_d0;
	logic             stb_d1;
	logic             hold;

	// either channel can freeze the card clock
	assign hold = cmd_hold | dat_hold;

	// one tick every div_factor+1 cycles
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else if (div_cnt >= div_factor) begin
			div_cnt <= '0;
			tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	// card clock, plus the delayed strobe after each rising edge
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			clk_q <= 1'b0;
			stb_d0 <= 1'b0;
			stb_d1 <= 1'b0;
		end else begin
			if (tick && !hold)
				clk_q <= ~clk_q;
			stb_d0 <= tick && !hold && !clk_q;
			stb_d1 <= stb_d0;
		end
	end

	assign mc_clk = clk_q;
	assign shift_stb = stb_d1;

	// a held clock produces no strobe once the delay line has drained
	a_no_stb_on_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(cmd_hold && dat_hold) [*3] |-> !$rose(shift_stb));

endmodule

// File: hdl/mc_line_pkg.sv
// ----------------------------------------------------------
// memory card controller, card line view
// line widths, value lengths, input synchronizer depth and
// the channel state encoding
// ----------------------------------------------------------

package mc_line_pkg;

	// command line, one lane carrying one byte
	localparam int cmd_lanes = 1;
	localparam int cmd_bits = 8;

	// data lines, four lanes carrying one word
	localparam int dat_lanes = 4;
	localparam int dat_bits = 32;

	// flip-flops between the pad and the shift register
	localparam int sync_depth = 3;

	// channel state
	typedef enum logic [2:0] {
		ch_idle,
		ch_tx,
		ch_rx_hunt,
		ch_rx_shift,
		ch_rx_full
	} mc_chan_state_t;

endpackage

// File: hdl/mc_regs_pkg.sv
// ----------------------------------------------------------
// memory card controller, software register view
// register window geometry, register index encoding and
// reset values seen through the register bus
// ----------------------------------------------------------

package mc_regs_pkg;

	// register bus geometry
	localparam int csr_addr_w = 14;
	localparam int csr_data_w = 32;

	// card clock divider
	localparam int div_w = 11;
	localparam logic [div_w-1:0] div_reset = 11'd1023;

	// register index, decoded from address bits 2 to 0
	typedef enum logic [2:0] {
		reg_divider = 3'd0,
		reg_enable  = 3'd1,
		reg_pending = 3'd2,
		reg_started = 3'd3,
		reg_cmd     = 3'd4,
		reg_dat     = 3'd5
	} mc_reg_t;

	// bit positions shared by the enable and pending registers
	localparam int en_cmd_tx = 0;
	localparam int en_cmd_rx = 1;
	localparam int en_dat_tx = 2;
	localparam int en_dat_rx = 3;

endpackage
